//--- Bender.yml
package:
  name: burst_splitter

sources:
  - files:
      - bus_pkg.sv
      - splitter_pkg.sv
      - splitter_ifs.sv
      - burst_req_splitter.sv
      - burst_len_tracker.sv
      - read_last_rebuilder.sv
      - burst_splitter_top.sv
  - target: test
    files:
      - burst_splitter_assertions.sv
      - tb_burst_splitter.sv

//--- burst_len_tracker.sv
/*
  Holds the remaining beat count of up to MAX_TXNS split bursts. Same-ID bursts
  retire in claim order; a slot is free whenever its counter is zero.
*/
`default_nettype none

module burst_len_tracker #(
  parameter int unsigned MAX_TXNS = 4,
  parameter int unsigned ID_WIDTH = 2
) (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  track_alloc_if.dst    alloc,
  track_read_if.dst     rd
);

  localparam int unsigned IDX_W = splitter_pkg::idx_width(MAX_TXNS);

  // Per-slot state
  logic [ID_WIDTH-1:0]  tag_q  [MAX_TXNS];
  splitter_pkg::cnt_t   cnt_q  [MAX_TXNS];
  logic [IDX_W-1:0]     wait_q [MAX_TXNS];

  logic [MAX_TXNS-1:0]  free, head_match;
  logic [IDX_W-1:0]     free_idx, rd_idx, claim_wait;
  splitter_pkg::cnt_t   rd_rem;
  logic                 claim, dec, retire;

  // ----------------------------------------
  // Slot choice and ID lookup
  // ----------------------------------------
  always_comb begin
    free_idx = '0;
    rd_idx   = '0;
    for (int i = MAX_TXNS - 1; i >= 0; i--) begin
      free[i]       = (cnt_q[i] == '0);
      head_match[i] = !free[i] && (wait_q[i] == '0) && (tag_q[i] == rd.id);
      // Downward scan leaves the lowest free index
      if (free[i]) begin
        free_idx = IDX_W'(i);
      end
      // At most one head per ID
      if (head_match[i]) begin
        rd_idx = IDX_W'(i);
      end
    end
  end

  assign alloc.gnt = |free;
  assign rd.gnt    = |head_match;

  // Beats left after the one being looked up
  assign rd_rem = cnt_q[rd_idx] - splitter_pkg::cnt_t'(1);
  assign rd.len = rd_rem[$bits(bus_pkg::len_t)-1:0];

  assign claim  = alloc.req && alloc.gnt;
  assign dec    = rd.req && rd.gnt && rd.dec;
  assign retire = dec && (rd_rem == '0);

  // Older live bursts of the claiming ID, not counting one retiring right now
  always_comb begin
    claim_wait = '0;
    for (int i = 0; i < MAX_TXNS; i++) begin
      if (!free[i] && (tag_q[i] == alloc.id)) begin
        if (!(retire && (IDX_W'(i) == rd_idx))) begin
          claim_wait = claim_wait + IDX_W'(1);
        end
      end
    end
  end

  // ----------------------------------------
  // Slot registers
  // ----------------------------------------
  for (genvar g = 0; g < MAX_TXNS; g++) begin : gen_slot
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q[g]  <= '0;
        wait_q[g] <= '0;
      end else if (claim && (free_idx == IDX_W'(g))) begin
        cnt_q[g]  <= splitter_pkg::cnt_init(alloc.len);
        wait_q[g] <= claim_wait;
      end else begin
        if (dec && (rd_idx == IDX_W'(g))) begin
          cnt_q[g] <= cnt_q[g] - splitter_pkg::cnt_t'(1);
        end
        // Successor of a retiring burst moves up one place
        if (retire && !free[g] && (wait_q[g] != '0) && (tag_q[g] == tag_q[rd_idx])) begin
          wait_q[g] <= wait_q[g] - IDX_W'(1);
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (claim && (free_idx == IDX_W'(g))) begin
        tag_q[g] <= alloc.id;
      end
    end
  end

endmodule

`default_nettype wire

//--- burst_req_splitter.sv
/*
  Splits each accepted AR burst into single-beat requests. Wrap bursts are
  treated like fixed ones; the address of an incr burst steps by one beat size.
*/
`default_nettype none

module burst_req_splitter #(
  parameter int unsigned ID_WIDTH   = 2,
  parameter int unsigned ADDR_WIDTH = 16
) (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  burst_req_if.dst      up,
  burst_req_if.src      down,
  track_alloc_if.src    alloc
);

  splitter_pkg::req_state_e state_d, state_q;

  // Remainder of the burst being split
  logic [ID_WIDTH-1:0]   id_d, id_q;
  logic [ADDR_WIDTH-1:0] addr_d, addr_q;
  bus_pkg::len_t         len_d, len_q;
  bus_pkg::size_t        size_d, size_q;
  bus_pkg::burst_e       burst_d, burst_q;

  // Address of the next piece
  function automatic logic [ADDR_WIDTH-1:0] step_addr(
    input logic [ADDR_WIDTH-1:0] addr,
    input bus_pkg::size_t        size,
    input bus_pkg::burst_e       burst
  );
    logic [ADDR_WIDTH-1:0] bytes;
    bytes = ADDR_WIDTH'(1) << size;
    return (burst == bus_pkg::BurstIncr) ? addr + bytes : addr;
  endfunction

  // Claim carries the full burst length
  assign alloc.id  = up.id;
  assign alloc.len = up.len;

  always_comb begin
    state_d  = state_q;
    id_d     = id_q;
    addr_d   = addr_q;
    len_d    = len_q;
    size_d   = size_q;
    burst_d  = burst_q;
    up.ready = 1'b0;
    alloc.req = 1'b0;
    // Pieces are always single beat
    down.id    = id_q;
    down.addr  = addr_q;
    down.len   = '0;
    down.size  = size_q;
    down.burst = burst_q;
    down.valid = 1'b0;

    case (state_q)
      splitter_pkg::ReqIdle: begin
        if (up.valid && alloc.gnt) begin
          down.id    = up.id;
          down.addr  = up.addr;
          down.size  = up.size;
          down.burst = up.burst;
          down.valid = 1'b1;
          if (up.len == '0) begin
            // Single beat already, pass through when downstream takes it
            up.ready  = down.ready;
            alloc.req = down.ready;
          end else begin
            // Store and acknowledge at once, first piece goes out now
            up.ready  = 1'b1;
            alloc.req = 1'b1;
            id_d      = up.id;
            size_d    = up.size;
            burst_d   = up.burst;
            len_d     = up.len;
            addr_d    = up.addr;
            if (down.ready) begin
              len_d  = up.len - bus_pkg::len_t'(1);
              addr_d = step_addr(up.addr, up.size, up.burst);
            end
            state_d = splitter_pkg::ReqBusy;
          end
        end
      end
      splitter_pkg::ReqBusy: begin
        down.valid = 1'b1;
        if (down.ready) begin
          if (len_q == '0) begin
            state_d = splitter_pkg::ReqIdle;
          end else begin
            len_d  = len_q - bus_pkg::len_t'(1);
            addr_d = step_addr(addr_q, size_q, burst_q);
          end
        end
      end
      default: state_d = splitter_pkg::ReqIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= splitter_pkg::ReqIdle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    id_q    <= id_d;
    addr_q  <= addr_d;
    len_q   <= len_d;
    size_q  <= size_d;
    burst_q <= burst_d;
  end

endmodule

`default_nettype wire

//--- burst_splitter_assertions.sv
/*
  Port-level checks on the burst splitter, bound into every burst_splitter_top.
  Failures raise $error and are counted in err_count.
*/
`default_nettype none

module burst_splitter_assertions #(
  parameter int unsigned ID_WIDTH   = 2,
  parameter int unsigned ADDR_WIDTH = 16,
  parameter int unsigned DATA_WIDTH = 32
) (
  input wire logic                  clk_i,
  input wire logic                  rst_ni,
  input wire bus_pkg::burst_e       s_ar_burst_i,
  input wire logic                  s_ar_valid_i,
  input wire logic                  s_ar_ready_o,
  input wire logic [ID_WIDTH-1:0]   m_ar_id_o,
  input wire logic [ADDR_WIDTH-1:0] m_ar_addr_o,
  input wire bus_pkg::len_t         m_ar_len_o,
  input wire bus_pkg::size_t        m_ar_size_o,
  input wire bus_pkg::burst_e       m_ar_burst_o,
  input wire logic                  m_ar_valid_o,
  input wire logic                  m_ar_ready_i,
  input wire logic [ID_WIDTH-1:0]   s_r_id_o,
  input wire logic [DATA_WIDTH-1:0] s_r_data_o,
  input wire bus_pkg::resp_e        s_r_resp_o,
  input wire logic                  s_r_last_o,
  input wire logic                  s_r_valid_o,
  input wire logic                  s_r_ready_i
);

  int unsigned err_count = 0;

  // Every downstream piece is a single beat
  a_single_beat: assert property (@(posedge clk_i) disable iff (!rst_ni)
    m_ar_valid_o |-> (m_ar_len_o == '0))
    else begin
      $error("downstream AR carries a nonzero length");
      err_count++;
    end

  // Wrap bursts are outside the supported set
  a_no_wrap: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (s_ar_valid_i && s_ar_ready_o) |-> (s_ar_burst_i != bus_pkg::BurstWrap))
    else begin
      $error("wrap burst accepted on the slave AR port");
      err_count++;
    end

  // Stalled AR keeps valid and fields
  a_ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (m_ar_valid_o && !m_ar_ready_i) |=> (m_ar_valid_o &&
      $stable({m_ar_id_o, m_ar_addr_o, m_ar_len_o, m_ar_size_o, m_ar_burst_o})))
    else begin
      $error("master AR changed before ready");
      err_count++;
    end

  // Stalled R keeps valid, payload and last
  a_r_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (s_r_valid_o && !s_r_ready_i) |=> (s_r_valid_o &&
      $stable({s_r_id_o, s_r_data_o, s_r_resp_o, s_r_last_o})))
    else begin
      $error("slave R changed before ready");
      err_count++;
    end

endmodule

bind burst_splitter_top burst_splitter_assertions #(
  .ID_WIDTH   (ID_WIDTH),
  .ADDR_WIDTH (ADDR_WIDTH),
  .DATA_WIDTH (DATA_WIDTH)
) i_burst_splitter_assertions (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .s_ar_burst_i (s_ar_burst_i),
  .s_ar_valid_i (s_ar_valid_i),
  .s_ar_ready_o (s_ar_ready_o),
  .m_ar_id_o    (m_ar_id_o),
  .m_ar_addr_o  (m_ar_addr_o),
  .m_ar_len_o   (m_ar_len_o),
  .m_ar_size_o  (m_ar_size_o),
  .m_ar_burst_o (m_ar_burst_o),
  .m_ar_valid_o (m_ar_valid_o),
  .m_ar_ready_i (m_ar_ready_i),
  .s_r_id_o     (s_r_id_o),
  .s_r_data_o   (s_r_data_o),
  .s_r_resp_o   (s_r_resp_o),
  .s_r_last_o   (s_r_last_o),
  .s_r_valid_o  (s_r_valid_o),
  .s_r_ready_i  (s_r_ready_i)
);

`default_nettype wire

//--- burst_splitter_top.sv
/*
  Read-path AXI burst splitter. AW, W and B are not handled, and wrap bursts
  are not supported. At most MAX_TXNS split bursts are outstanding.
*/
`default_nettype none

module burst_splitter_top #(
  parameter int unsigned MAX_TXNS   = 4,
  parameter int unsigned ID_WIDTH   = 2,
  parameter int unsigned ADDR_WIDTH = 16,
  parameter int unsigned DATA_WIDTH = 32
) (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  // Slave AR
  input  wire logic [ID_WIDTH-1:0]   s_ar_id_i,
  input  wire logic [ADDR_WIDTH-1:0] s_ar_addr_i,
  input  wire bus_pkg::len_t         s_ar_len_i,
  input  wire bus_pkg::size_t        s_ar_size_i,
  input  wire bus_pkg::burst_e       s_ar_burst_i,
  input  wire logic                  s_ar_valid_i,
  output logic                       s_ar_ready_o,
  // Master AR
  output logic [ID_WIDTH-1:0]        m_ar_id_o,
  output logic [ADDR_WIDTH-1:0]      m_ar_addr_o,
  output bus_pkg::len_t              m_ar_len_o,
  output bus_pkg::size_t             m_ar_size_o,
  output bus_pkg::burst_e            m_ar_burst_o,
  output logic                       m_ar_valid_o,
  input  wire logic                  m_ar_ready_i,
  // Master R
  input  wire logic [ID_WIDTH-1:0]   m_r_id_i,
  input  wire logic [DATA_WIDTH-1:0] m_r_data_i,
  input  wire bus_pkg::resp_e        m_r_resp_i,
  input  wire logic                  m_r_valid_i,
  output logic                       m_r_ready_o,
  // Slave R
  output logic [ID_WIDTH-1:0]        s_r_id_o,
  output logic [DATA_WIDTH-1:0]      s_r_data_o,
  output bus_pkg::resp_e             s_r_resp_o,
  output logic                       s_r_last_o,
  output logic                       s_r_valid_o,
  input  wire logic                  s_r_ready_i
);

  burst_req_if   #(.ID_WIDTH(ID_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) ar_up ();
  burst_req_if   #(.ID_WIDTH(ID_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) ar_down ();
  track_alloc_if #(.ID_WIDTH(ID_WIDTH)) alloc ();
  track_read_if  #(.ID_WIDTH(ID_WIDTH)) rd ();

  // ----------------------------------------
  // AR port mapping
  // ----------------------------------------
  assign ar_up.id     = s_ar_id_i;
  assign ar_up.addr   = s_ar_addr_i;
  assign ar_up.len    = s_ar_len_i;
  assign ar_up.size   = s_ar_size_i;
  assign ar_up.burst  = s_ar_burst_i;
  assign ar_up.valid  = s_ar_valid_i;
  assign s_ar_ready_o = ar_up.ready;

  assign m_ar_id_o     = ar_down.id;
  assign m_ar_addr_o   = ar_down.addr;
  assign m_ar_len_o    = ar_down.len;
  assign m_ar_size_o   = ar_down.size;
  assign m_ar_burst_o  = ar_down.burst;
  assign m_ar_valid_o  = ar_down.valid;
  assign ar_down.ready = m_ar_ready_i;

  // ----------------------------------------
  // Submodules
  // ----------------------------------------
  burst_req_splitter #(
    .ID_WIDTH   (ID_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) i_burst_req_splitter (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .up     (ar_up),
    .down   (ar_down),
    .alloc  (alloc)
  );

  burst_len_tracker #(
    .MAX_TXNS (MAX_TXNS),
    .ID_WIDTH (ID_WIDTH)
  ) i_burst_len_tracker (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .alloc  (alloc),
    .rd     (rd)
  );

  read_last_rebuilder #(
    .ID_WIDTH   (ID_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) i_read_last_rebuilder (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd          (rd),
    .m_r_id_i    (m_r_id_i),
    .m_r_data_i  (m_r_data_i),
    .m_r_resp_i  (m_r_resp_i),
    .m_r_valid_i (m_r_valid_i),
    .m_r_ready_o (m_r_ready_o),
    .s_r_id_o    (s_r_id_o),
    .s_r_data_o  (s_r_data_o),
    .s_r_resp_o  (s_r_resp_o),
    .s_r_last_o  (s_r_last_o),
    .s_r_valid_o (s_r_valid_o),
    .s_r_ready_i (s_r_ready_i)
  );

endmodule

`default_nettype wire

//--- bus_pkg.sv
/*
  Read-channel field types shared by the splitter RTL and its testbench.
  Only the fields the splitter acts on are modelled; lock, cache, prot, qos are absent.
*/
`default_nettype none

package bus_pkg;

  // ----------------------------------------
  // Address channel fields
  // ----------------------------------------

  // Beats minus one of a burst
  typedef logic [7:0] len_t;

  // log2 of the bytes moved per beat
  typedef logic [2:0] size_t;

  // Burst address behaviour
  // Wrap is encoded but not supported by the splitter
  typedef enum logic [1:0] {
    BurstFixed = 2'b00,
    BurstIncr  = 2'b01,
    BurstWrap  = 2'b10
  } burst_e;

  // ----------------------------------------
  // Read data channel fields
  // ----------------------------------------

  // Response code returned with every R beat
  typedef enum logic [1:0] {
    RespOkay   = 2'b00,
    RespExokay = 2'b01,
    RespSlverr = 2'b10,
    RespDecerr = 2'b11
  } resp_e;

endpackage

`default_nettype wire

//--- compile.f
bus_pkg.sv
splitter_pkg.sv
splitter_ifs.sv
burst_req_splitter.sv
burst_len_tracker.sv
read_last_rebuilder.sv
burst_splitter_top.sv
burst_splitter_assertions.sv
tb_burst_splitter.sv

//--- read_last_rebuilder.sv
/*
  Restores R last from the tracker counts. A beat is only forwarded once its
  ID has a head slot in the tracker, so responses for unknown IDs stall.
*/
`default_nettype none

module read_last_rebuilder #(
  parameter int unsigned ID_WIDTH   = 2,
  parameter int unsigned DATA_WIDTH = 32
) (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  track_read_if.src                  rd,
  // Downstream R
  input  wire logic [ID_WIDTH-1:0]   m_r_id_i,
  input  wire logic [DATA_WIDTH-1:0] m_r_data_i,
  input  wire bus_pkg::resp_e        m_r_resp_i,
  input  wire logic                  m_r_valid_i,
  output logic                       m_r_ready_o,
  // Upstream R
  output logic [ID_WIDTH-1:0]        s_r_id_o,
  output logic [DATA_WIDTH-1:0]      s_r_data_o,
  output bus_pkg::resp_e             s_r_resp_o,
  output logic                       s_r_last_o,
  output logic                       s_r_valid_o,
  input  wire logic                  s_r_ready_i
);

  splitter_pkg::r_state_e state_d, state_q;
  logic                   last_d, last_q;

  // Payload is untouched, only last is rebuilt
  assign s_r_id_o   = m_r_id_i;
  assign s_r_data_o = m_r_data_i;
  assign s_r_resp_o = m_r_resp_i;
  assign rd.id      = m_r_id_i;

  always_comb begin
    state_d     = state_q;
    last_d      = last_q;
    rd.req      = 1'b0;
    rd.dec      = 1'b0;
    m_r_ready_o = 1'b0;
    s_r_valid_o = 1'b0;
    s_r_last_o  = 1'b0;

    case (state_q)
      splitter_pkg::RFeed: begin
        if (m_r_valid_i) begin
          rd.req = 1'b1;
          if (rd.gnt) begin
            // Counter moves on now, even if upstream stalls
            last_d      = (rd.len == '0);
            rd.dec      = 1'b1;
            s_r_last_o  = last_d;
            s_r_valid_o = 1'b1;
            if (s_r_ready_i) begin
              m_r_ready_o = 1'b1;
            end else begin
              state_d = splitter_pkg::RWait;
            end
          end
        end
      end
      splitter_pkg::RWait: begin
        // Same beat again with the stored last, no second decrement
        s_r_last_o  = last_q;
        s_r_valid_o = m_r_valid_i;
        if (m_r_valid_i && s_r_ready_i) begin
          m_r_ready_o = 1'b1;
          state_d     = splitter_pkg::RFeed;
        end
      end
      default: state_d = splitter_pkg::RFeed;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= splitter_pkg::RFeed;
      last_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      last_q  <= last_d;
    end
  end

endmodule

`default_nettype wire

//--- splitter_ifs.sv
/*
  Internal handshakes of the splitter. Transfers happen on a rising edge with
  valid/req and ready/gnt both high; tracker grants are combinational.
*/
`default_nettype none

// AR request between top, splitter and downstream port
interface burst_req_if #(
  parameter int unsigned ID_WIDTH   = 2,
  parameter int unsigned ADDR_WIDTH = 16
);
  logic [ID_WIDTH-1:0]   id;
  logic [ADDR_WIDTH-1:0] addr;
  bus_pkg::len_t         len;
  bus_pkg::size_t        size;
  bus_pkg::burst_e       burst;
  logic                  valid;
  logic                  ready;

  // Fields hold from valid until the transfer
  modport src (output id, addr, len, size, burst, valid, input ready);
  modport dst (input id, addr, len, size, burst, valid, output ready);
endinterface

// Slot claim from the splitter into the tracker
interface track_alloc_if #(
  parameter int unsigned ID_WIDTH = 2
);
  logic [ID_WIDTH-1:0] id;
  bus_pkg::len_t       len;
  logic                req;
  logic                gnt;

  modport src (output id, len, req, input gnt);
  modport dst (input id, len, req, output gnt);
endinterface

// Per-beat lookup and decrement from the rebuilder
interface track_read_if #(
  parameter int unsigned ID_WIDTH = 2
);
  logic [ID_WIDTH-1:0] id;
  bus_pkg::len_t       len;
  logic                dec;
  logic                req;
  logic                gnt;

  modport src (output id, dec, req, input len, gnt);
  modport dst (input id, dec, req, output len, gnt);
endinterface

`default_nettype wire

//--- splitter_pkg.sv
/*
  Splitter internals: FSM states and sizing of the tracker counters and slot index.
*/
`default_nettype none

package splitter_pkg;

  // AR side: waiting for a burst, or emitting its single-beat pieces
  typedef enum logic {ReqIdle, ReqBusy} req_state_e;

  // R side: forwarding beats, or holding one beat for upstream ready
  typedef enum logic {RFeed, RWait} r_state_e;

  // Remaining beats of a slot, one bit wider so len 255 still fits as 256
  typedef logic [$bits(bus_pkg::len_t):0] cnt_t;

  // Slot index width, never below one bit
  function automatic int unsigned idx_width(input int unsigned max_txns);
    return (max_txns > 1) ? $clog2(max_txns) : 1;
  endfunction

  // Counter value loaded when a slot is claimed
  function automatic cnt_t cnt_init(input bus_pkg::len_t len);
    return {1'b0, len} + cnt_t'(1);
  endfunction

endpackage

`default_nettype wire

//--- tb_burst_splitter.sv
/*
  Testbench for burst_splitter_top with default parameters. The downstream memory
  keeps per-ID order only; it answers one beat at a time with okay responses.
*/
`default_nettype none

module tb_burst_splitter;

  localparam int unsigned MAX_TXNS   = 4;
  localparam int unsigned ID_WIDTH   = 2;
  localparam int unsigned ADDR_WIDTH = 16;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned NUM_REQS   = 11;

  typedef struct packed {
    logic [ID_WIDTH-1:0]   id;
    logic [ADDR_WIDTH-1:0] addr;
    bus_pkg::len_t         len;
    bus_pkg::size_t        size;
    bus_pkg::burst_e       burst;
    logic                  hold;
  } req_t;

  typedef struct packed {
    logic [ID_WIDTH-1:0]   id;
    logic [ADDR_WIDTH-1:0] addr;
    bus_pkg::size_t        size;
    bus_pkg::burst_e       burst;
  } ar_exp_t;

  typedef struct packed {
    logic [ID_WIDTH-1:0]   id;
    logic [ADDR_WIDTH-1:0] addr;
    logic                  last;
  } r_exp_t;

  typedef struct packed {
    logic [ID_WIDTH-1:0]   id;
    logic [ADDR_WIDTH-1:0] addr;
  } mem_req_t;

  logic                  clk_i, rst_ni;
  logic [ID_WIDTH-1:0]   s_ar_id_i, m_ar_id_o, m_r_id_i, s_r_id_o;
  logic [ADDR_WIDTH-1:0] s_ar_addr_i, m_ar_addr_o;
  bus_pkg::len_t         s_ar_len_i, m_ar_len_o;
  bus_pkg::size_t        s_ar_size_i, m_ar_size_o;
  bus_pkg::burst_e       s_ar_burst_i, m_ar_burst_o;
  logic                  s_ar_valid_i, s_ar_ready_o, m_ar_valid_o, m_ar_ready_i;
  logic [DATA_WIDTH-1:0] m_r_data_i, s_r_data_o;
  bus_pkg::resp_e        m_r_resp_i, s_r_resp_o;
  logic                  m_r_valid_i, m_r_ready_o;
  logic                  s_r_last_o, s_r_valid_o, s_r_ready_i;

  // Columns: id, addr, len, size, burst, hold responses
  // First four are held to fill every tracker slot, the fifth probes capacity
  req_t tbl [NUM_REQS] = '{
    '{2'd0, 16'h1000, 8'd3,  3'd2, bus_pkg::BurstIncr,  1'b1},
    '{2'd1, 16'h2000, 8'd1,  3'd1, bus_pkg::BurstIncr,  1'b1},
    '{2'd2, 16'h3000, 8'd0,  3'd2, bus_pkg::BurstIncr,  1'b1},
    '{2'd0, 16'h1100, 8'd2,  3'd3, bus_pkg::BurstFixed, 1'b1},
    '{2'd3, 16'h4000, 8'd1,  3'd2, bus_pkg::BurstIncr,  1'b0},
    '{2'd1, 16'h5000, 8'd7,  3'd2, bus_pkg::BurstIncr,  1'b0},
    '{2'd1, 16'h5100, 8'd3,  3'd2, bus_pkg::BurstIncr,  1'b0},
    '{2'd2, 16'h6000, 8'd5,  3'd0, bus_pkg::BurstIncr,  1'b0},
    '{2'd3, 16'h7000, 8'd0,  3'd2, bus_pkg::BurstFixed, 1'b0},
    '{2'd0, 16'h8000, 8'd15, 3'd2, bus_pkg::BurstIncr,  1'b0},
    '{2'd2, 16'h9002, 8'd2,  3'd1, bus_pkg::BurstFixed, 1'b0}
  };

  ar_exp_t     exp_ar [$];
  r_exp_t      exp_r  [$];
  mem_req_t    mem_q  [$];
  logic [31:0] lfsr_q;
  logic        stim_on, hold_resp, r_busy, last_seen, full;
  int          held, cycles, limit;

  burst_splitter_top i_burst_splitter_top (.*);

  always #10 clk_i = ~clk_i;

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on first error");
  endtask

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
  endtask

  // Memory contents as a function of the address
  function automatic logic [DATA_WIDTH-1:0] mem_data(input logic [ADDR_WIDTH-1:0] a);
    return {a ^ 16'hc3a5, 16'(a * 16'd40503)};
  endfunction

  function automatic int timeout_limit();
    int sum;
    sum = 200;
    for (int i = 0; i < NUM_REQS; i++) begin
      sum += (int'(tbl[i].len) + 1) * 10;
    end
    return sum;
  endfunction

  // Expected pieces and beats of one burst
  task automatic predict(input req_t r);
    logic [ADDR_WIDTH-1:0] a;
    for (int k = 0; k <= int'(r.len); k++) begin
      // Piece k of an incr burst sits k beats of 2**size bytes past the base
      a = r.addr;
      if (r.burst == bus_pkg::BurstIncr) begin
        a = r.addr + ADDR_WIDTH'(k * (2 ** int'(r.size)));
      end
      exp_ar.push_back({r.id, a, r.size, r.burst});
      exp_r.push_back({r.id, a, (k == int'(r.len))});
    end
  endtask

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------
  task automatic check_ctrl(input string name, input logic exp_val, input logic got_val);
    if (got_val !== exp_val)
      abort_run($sformatf("mismatch %s: expected %h, got %h", name, exp_val, got_val));
  endtask

  task automatic check_ar(
    input logic [ID_WIDTH-1:0]   exp_id,
    input logic [ADDR_WIDTH-1:0] exp_addr,
    input bus_pkg::len_t         exp_len,
    input bus_pkg::size_t        exp_size,
    input bus_pkg::burst_e       exp_burst
  );
    if (m_ar_id_o !== exp_id)
      abort_run($sformatf("mismatch m_ar_id_o: expected %h, got %h", exp_id, m_ar_id_o));
    if (m_ar_addr_o !== exp_addr)
      abort_run($sformatf("mismatch m_ar_addr_o: expected %h, got %h", exp_addr, m_ar_addr_o));
    if (m_ar_len_o !== exp_len)
      abort_run($sformatf("mismatch m_ar_len_o: expected %h, got %h", exp_len, m_ar_len_o));
    if (m_ar_size_o !== exp_size)
      abort_run($sformatf("mismatch m_ar_size_o: expected %h, got %h", exp_size, m_ar_size_o));
    if (m_ar_burst_o !== exp_burst)
      abort_run($sformatf("mismatch m_ar_burst_o: expected %h, got %h",
                          exp_burst, m_ar_burst_o));
  endtask

  task automatic check_r(
    input logic [ID_WIDTH-1:0]   exp_id,
    input logic [DATA_WIDTH-1:0] exp_data,
    input bus_pkg::resp_e        exp_resp,
    input logic                  exp_last
  );
    if (s_r_id_o !== exp_id)
      abort_run($sformatf("mismatch s_r_id_o: expected %h, got %h", exp_id, s_r_id_o));
    if (s_r_data_o !== exp_data)
      abort_run($sformatf("mismatch s_r_data_o: expected %h, got %h", exp_data, s_r_data_o));
    if (s_r_resp_o !== exp_resp)
      abort_run($sformatf("mismatch s_r_resp_o: expected %h, got %h", exp_resp, s_r_resp_o));
    if (s_r_last_o !== exp_last)
      abort_run($sformatf("mismatch s_r_last_o: expected %h, got %h", exp_last, s_r_last_o));
  endtask

  task automatic check_idle();
    check_ctrl("s_ar_ready_o", 1'b0, s_ar_ready_o);
    check_ctrl("m_ar_valid_o", 1'b0, m_ar_valid_o);
    check_ctrl("s_r_valid_o", 1'b0, s_r_valid_o);
    check_ctrl("m_r_ready_o", 1'b0, m_r_ready_o);
  endtask

  // ----------------------------------------
  // Monitor and scoreboard
  // ----------------------------------------
  always @(posedge clk_i) begin : monitor
    int k;
    cycles++;
    if (cycles > limit)
      abort_run($sformatf("timeout: traffic did not finish within %0d cycles", limit));
    if (i_burst_splitter_top.i_burst_splitter_assertions.err_count != 0)
      abort_run("a concurrent assertion on the DUT ports failed");
    if (m_ar_valid_o && m_ar_ready_i) begin
      if (exp_ar.size() == 0)
        abort_run("downstream AR issued with no request pending");
      check_ar(exp_ar[0].id, exp_ar[0].addr, bus_pkg::len_t'(0), exp_ar[0].size,
               exp_ar[0].burst);
      void'(exp_ar.pop_front());
      mem_q.push_back({m_ar_id_o, m_ar_addr_o});
    end
    if (m_r_valid_i && m_r_ready_o) r_busy = 1'b0;
    if (s_r_valid_o && s_r_last_o) last_seen = 1'b1;
    if (s_r_valid_o && s_r_ready_i) begin
      // Oldest outstanding beat of the ID the memory is returning
      k = -1;
      for (int j = exp_r.size() - 1; j >= 0; j--) begin
        if (exp_r[j].id == m_r_id_i) k = j;
      end
      if (k < 0)
        abort_run($sformatf("upstream R beat with ID %h was not expected", m_r_id_i));
      check_r(exp_r[k].id, mem_data(exp_r[k].addr), bus_pkg::RespOkay, exp_r[k].last);
      exp_r.delete(k);
    end
  end

  // Random ready gaps and downstream R beats, per-ID order kept
  always @(negedge clk_i) begin : mem_model
    logic [31:0] r;
    int          k;
    if (stim_on) begin
      draw_bits(2, r);
      m_ar_ready_i = |r[1:0];
      draw_bits(2, r);
      s_r_ready_i = |r[1:0];
      if (!r_busy) m_r_valid_i = 1'b0;
      if (!r_busy && !hold_resp && (mem_q.size() != 0)) begin
        draw_bits(2, r);
        if (|r[1:0]) begin
          draw_bits(ID_WIDTH, r);
          k = 0;
          for (int j = mem_q.size() - 1; j >= 0; j--) begin
            if (mem_q[j].id == r[ID_WIDTH-1:0]) k = j;
          end
          m_r_id_i    = mem_q[k].id;
          m_r_data_i  = mem_data(mem_q[k].addr);
          m_r_resp_i  = bus_pkg::RespOkay;
          m_r_valid_i = 1'b1;
          r_busy      = 1'b1;
          mem_q.delete(k);
        end
      end
    end
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin
    clk_i = 1'b0;
    rst_ni = 1'b0;
    {s_ar_id_i, s_ar_addr_i, s_ar_len_i, s_ar_size_i, s_ar_valid_i} = '0;
    s_ar_burst_i = bus_pkg::BurstIncr;
    {m_ar_ready_i, m_r_id_i, m_r_data_i, m_r_valid_i, s_r_ready_i} = '0;
    m_r_resp_i = bus_pkg::RespOkay;
    {stim_on, hold_resp, r_busy, last_seen, full} = '0;
    lfsr_q = 32'he75;
    held   = 0;
    cycles = 0;
    limit  = timeout_limit();

    // Reset, outputs stay quiet until traffic starts
    repeat (8) begin
      @(posedge clk_i);
      check_idle();
    end
    @(negedge clk_i);
    rst_ni = 1'b1;
    repeat (3) begin
      @(posedge clk_i);
      check_idle();
    end
    stim_on = 1'b1;
    @(negedge clk_i);

    for (int i = 0; i < NUM_REQS; i++) begin
      // Held group starts from an empty tracker
      if (tbl[i].hold && !hold_resp) begin
        while (exp_r.size() != 0) @(posedge clk_i);
        @(posedge clk_i);
        hold_resp = 1'b1;
        held      = 0;
        last_seen = 1'b0;
        @(negedge clk_i);
      end
      predict(tbl[i]);
      s_ar_id_i    = tbl[i].id;
      s_ar_addr_i  = tbl[i].addr;
      s_ar_len_i   = tbl[i].len;
      s_ar_size_i  = tbl[i].size;
      s_ar_burst_i = tbl[i].burst;
      s_ar_valid_i = 1'b1;
      full = 1'b0;
      if (!tbl[i].hold && hold_resp) begin
        // All slots busy, the request must wait
        full = (held >= MAX_TXNS);
        if (full) begin
          repeat (4) begin
            @(posedge clk_i);
            check_ctrl("s_ar_ready_o", 1'b0, s_ar_ready_o);
          end
        end
        @(posedge clk_i);
        hold_resp = 1'b0;
      end
      do @(posedge clk_i); while (!s_ar_ready_o);
      if (full && !last_seen)
        abort_run("burst accepted before any held burst returned its last beat");
      if (tbl[i].hold) held++;
      @(negedge clk_i);
      s_ar_valid_i = 1'b0;
    end

    while ((exp_r.size() != 0) || (exp_ar.size() != 0)) @(posedge clk_i);
    repeat (5) @(posedge clk_i);
    if (i_burst_splitter_top.i_burst_splitter_assertions.err_count != 0) begin
      abort_run("a concurrent assertion on the DUT ports failed");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire
